//--- hdl/bfp_macros.svh
`ifndef BFP_MACROS_SVH
`define BFP_MACROS_SVH

// block format
`define BFP_GRP_SIZE      16
`define BFP_EXP_W         8
`define BFP_FRAC_W        3     // element fraction 0.fff

// datapath widths
`define BFP_PROD_W        6     // 0.ffffff
`define BFP_TREE_LEVELS   4
`define BFP_SUM_W         10    // 16 * 49 fits in 10 bits
`define BFP_SUM_BIN_POINT 6

// single precision output
`define FP_EXP_W          8
`define FP_FRAC_W         23
`define FP_EXP_MAX        255

`endif

//--- hdl/bfp_pkg.sv
`default_nettype none

`include "bfp_macros.svh"

package bfp_pkg;

    typedef struct packed {
        logic                   sign;
        logic [`BFP_FRAC_W-1:0] frac;
    } bfp_elem_t;

    typedef struct packed {
        logic [`BFP_EXP_W-1:0]            exp;
        bfp_elem_t [`BFP_GRP_SIZE-1:0]    elem;
    } bfp_block_t;

    // one extra bit for the carry out of the exponent add
    typedef logic [`BFP_EXP_W:0] exp_sum_t;

    typedef struct packed {
        logic                   sign;
        logic [`BFP_PROD_W-1:0] mag;
    } bfp_prod_t;

    typedef struct packed {
        exp_sum_t                         exp_sum;
        bfp_prod_t [`BFP_GRP_SIZE-1:0]    prod;
    } bfp_prod_vec_t;

    typedef struct packed {
        logic                  sign;
        logic [`BFP_SUM_W-1:0] mag;
    } bfp_sum_t;

    typedef struct packed {
        exp_sum_t exp_sum;
        bfp_sum_t sum;
    } bfp_acc_t;

    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;   // hidden one not stored
    } fp32_t;

endpackage

`default_nettype wire

//--- hdl/bfp_product_array.sv
`timescale 1ns/1ns
`default_nettype none

`include "bfp_macros.svh"

module bfp_product_array
    import bfp_pkg::*;
(
    input  wire logic          i_clk,
    input  wire logic          i_reset_n,
    input  wire logic          i_valid,
    input  wire bfp_block_t    i_act,
    input  wire bfp_block_t    i_weight,
    output logic               o_valid,
    output bfp_prod_vec_t      o_prod
);

    localparam int PROD_MAX = (2**`BFP_FRAC_W - 1) ** 2;   // 7 * 7

    bfp_prod_vec_t prod_next;

    always_comb begin
        prod_next.exp_sum = {1'b0, i_act.exp} + {1'b0, i_weight.exp};
        for (int i = 0; i < `BFP_GRP_SIZE; i++) begin
            prod_next.prod[i].sign = i_act.elem[i].sign ^ i_weight.elem[i].sign;
            // 0.fff * 0.fff = 0.ffffff
            prod_next.prod[i].mag  = i_act.elem[i].frac * i_weight.elem[i].frac;
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_prod <= '0;
        end else if (i_valid) begin
            o_prod <= prod_next;   // held while idle
        end
    end

    for (genvar i = 0; i < `BFP_GRP_SIZE; i++) begin : g_chk
        a_prod_range: assert property (
            @(posedge i_clk) disable iff (!i_reset_n)
            o_valid |-> (o_prod.prod[i].mag <= PROD_MAX)
        ) else $error("product %0d out of range: %0d", i, o_prod.prod[i].mag);
    end

endmodule

`default_nettype wire

//--- hdl/bfp_adder_tree.sv
`timescale 1ns/1ns
`default_nettype none

`include "bfp_macros.svh"

module bfp_adder_tree
    import bfp_pkg::*;
(
    input  wire logic          i_clk,
    input  wire logic          i_reset_n,
    input  wire logic          i_valid,
    input  wire bfp_prod_vec_t i_prod,
    output logic               o_valid,
    output bfp_acc_t           o_acc
);

    localparam int PROD_MAX = (2**`BFP_FRAC_W - 1) ** 2;
    localparam int SUM_MAX  = `BFP_GRP_SIZE * PROD_MAX;   // 784
    localparam int PAD_W    = `BFP_SUM_W - `BFP_PROD_W;

    bfp_sum_t root;

    // sign-magnitude add
    // on a tie of opposite signs the first operand's sign wins
    function automatic bfp_sum_t sm_add(input bfp_sum_t a, input bfp_sum_t b);
        bfp_sum_t r;
        if (a.sign == b.sign) begin
            r.sign = a.sign;
            r.mag  = a.mag + b.mag;
        end else if (a.mag >= b.mag) begin
            r.sign = a.sign;
            r.mag  = a.mag - b.mag;
        end else begin
            r.sign = b.sign;
            r.mag  = b.mag - a.mag;
        end
        return r;
    endfunction

    // level 0 holds the widened products, each later level halves the count
    for (genvar lv = 0; lv <= `BFP_TREE_LEVELS; lv++) begin : g_lvl
        bfp_sum_t s [`BFP_GRP_SIZE >> lv];

        if (lv == 0) begin : g_leaf
            for (genvar i = 0; i < `BFP_GRP_SIZE; i++) begin : g_ext
                assign s[i] = {i_prod.prod[i].sign, {PAD_W{1'b0}}, i_prod.prod[i].mag};
            end
        end else begin : g_add
            for (genvar j = 0; j < (`BFP_GRP_SIZE >> lv); j++) begin : g_pair
                assign s[j] = sm_add(g_lvl[lv-1].s[2*j], g_lvl[lv-1].s[2*j+1]);
            end
        end
    end

    assign root = g_lvl[`BFP_TREE_LEVELS].s[0];

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_acc <= '0;
        end else if (i_valid) begin
            o_acc.exp_sum <= i_prod.exp_sum;   // travels with its sum
            o_acc.sum     <= root;
        end
    end

    // bound over all sixteen products of the previous stage
    a_sum_range: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        o_valid |-> (o_acc.sum.mag <= SUM_MAX)
    ) else $error("tree sum out of range: %0d", o_acc.sum.mag);

endmodule

`default_nettype wire

//--- hdl/fp_normalize.sv
`timescale 1ns/1ns
`default_nettype none

`include "bfp_macros.svh"

module fp_normalize
    import bfp_pkg::*;
(
    input  wire logic     i_clk,
    input  wire logic     i_reset_n,
    input  wire logic     i_valid,
    input  wire bfp_acc_t i_acc,
    output logic          o_valid,
    output fp32_t         o_result
);

    localparam int POS_W  = $clog2(`BFP_SUM_W);
    localparam int CAND_W = `BFP_EXP_W + 3;   // signed, covers -6 .. 519
    localparam int LOW_W  = `FP_FRAC_W - (`BFP_SUM_W - 1);

    localparam logic [POS_W-1:0]         TOP_POS   = POS_W'(`BFP_SUM_W - 1);
    localparam logic signed [CAND_W-1:0] BIN_POINT = CAND_W'(`BFP_SUM_BIN_POINT);
    localparam logic signed [CAND_W-1:0] EXP_LIMIT = CAND_W'(`FP_EXP_MAX - 1);
    localparam logic [`FP_EXP_W-1:0]     EXP_INF   = `FP_EXP_W'(`FP_EXP_MAX);

    logic [`BFP_SUM_W-1:0]    mag;
    logic [POS_W-1:0]         lead_pos;
    logic [POS_W-1:0]         shift_amt;
    logic [`BFP_SUM_W-1:0]    norm_mag;
    logic signed [CAND_W-1:0] cand_exp;
    logic                     is_zero;
    logic                     is_flush;
    logic                     is_ovf;
    fp32_t                    result_next;

    assign mag = i_acc.sum.mag;

    // leading one, highest set bit wins
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < `BFP_SUM_W; i++) begin
            if (mag[i]) begin
                lead_pos = POS_W'(i);
            end
        end
    end

    // move the leading one to the top bit so it drops out as the hidden one
    assign shift_amt = TOP_POS - lead_pos;
    assign norm_mag  = mag << shift_amt;

    // value = S * 2^-6 * 2^exp_sum, leading one at p gives exp_sum + p - 6
    assign cand_exp = $signed({2'b00, i_acc.exp_sum})
                    + $signed({{(CAND_W-POS_W){1'b0}}, lead_pos})
                    - BIN_POINT;

    assign is_zero  = (mag == '0);
    assign is_flush = cand_exp[CAND_W-1] || (cand_exp == '0);   // exponent <= 0
    assign is_ovf   = (cand_exp > EXP_LIMIT);

    always_comb begin
        if (is_zero || is_flush) begin
            result_next = '0;   // no negative zero
        end else if (is_ovf) begin
            result_next.sign = i_acc.sum.sign;
            result_next.exp  = EXP_INF;
            result_next.frac = '0;
        end else begin
            result_next.sign = i_acc.sum.sign;
            result_next.exp  = cand_exp[`FP_EXP_W-1:0];
            result_next.frac = {norm_mag[`BFP_SUM_W-2:0], {LOW_W{1'b0}}};
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_result <= '0;
        end else if (i_valid) begin
            o_result <= result_next;
        end
    end

    // infinity only, never a NaN pattern
    a_inf_frac: assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        (o_valid && (o_result.exp == EXP_INF)) |-> (o_result.frac == '0)
    ) else $error("exponent 255 with fraction %h", o_result.frac);

endmodule

`default_nettype wire

//--- hdl/bfp_dot_product.sv
`timescale 1ns/1ns
`default_nettype none

module bfp_dot_product
    import bfp_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_reset_n,
    input  wire logic       i_valid,
    input  wire bfp_block_t i_act,
    input  wire bfp_block_t i_weight,
    output logic            o_valid,
    output fp32_t           o_result
);

    logic          prod_valid;
    bfp_prod_vec_t prod_vec;
    logic          acc_valid;
    bfp_acc_t      acc;

    // stage 1
    bfp_product_array bfp_product_array_inst (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_valid   (i_valid),
        .i_act     (i_act),
        .i_weight  (i_weight),
        .o_valid   (prod_valid),
        .o_prod    (prod_vec)
    );

    // stage 2
    bfp_adder_tree bfp_adder_tree_inst (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_valid   (prod_valid),
        .i_prod    (prod_vec),
        .o_valid   (acc_valid),
        .o_acc     (acc)
    );

    // stage 3, drives the outputs directly
    fp_normalize fp_normalize_inst (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_valid   (acc_valid),
        .i_acc     (acc),
        .o_valid   (o_valid),
        .o_result  (o_result)
    );

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_clk = ~o_clk;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_bfp_dot_product.sv
`timescale 1ns/1ns
`default_nettype none

`include "bfp_macros.svh"

module tb_bfp_dot_product
    import bfp_pkg::*;
();

    localparam int CLK_PERIOD     = 4;
    localparam int N_STROBES      = 127;   // all strobes of all tests
    localparam int TIMEOUT_CYCLES = N_STROBES * 8 + 200;
    localparam int HALF           = `BFP_GRP_SIZE / 2;

    logic       clk;
    logic       reset_n;
    logic       in_valid;
    bfp_block_t in_act;
    bfp_block_t in_weight;
    logic       out_valid;
    fp32_t      out_result;

    fp32_t      exp_q[$];
    logic [2:0] vld_hist;   // strobes seen at the last three rising edges

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) tb_clock_gen_inst (
        .o_clk (clk)
    );

    bfp_dot_product bfp_dot_product_inst (
        .i_clk     (clk),
        .i_reset_n (reset_n),
        .i_valid   (in_valid),
        .i_act     (in_act),
        .i_weight  (in_weight),
        .o_valid   (out_valid),
        .o_result  (out_result)
    );

    // expected word from the signed sum of all sixteen products
    function automatic fp32_t expected_result(input bfp_block_t act, input bfp_block_t wgt);
        int    sum;
        int    mag;
        int    p;
        int    e;
        fp32_t r;
        sum = 0;
        for (int i = 0; i < `BFP_GRP_SIZE; i++) begin
            if (act.elem[i].sign ^ wgt.elem[i].sign) begin
                sum = sum - int'(act.elem[i].frac) * int'(wgt.elem[i].frac);
            end else begin
                sum = sum + int'(act.elem[i].frac) * int'(wgt.elem[i].frac);
            end
        end
        mag = (sum < 0) ? -sum : sum;
        r   = '0;
        if (mag != 0) begin
            p = 0;
            for (int b = 0; b < 16; b++) begin
                if (mag >= (1 << b)) begin
                    p = b;
                end
            end
            e = int'(act.exp) + int'(wgt.exp) + p - `BFP_SUM_BIN_POINT;
            if (e > `FP_EXP_MAX - 1) begin
                r.sign = (sum < 0);
                r.exp  = `FP_EXP_W'(`FP_EXP_MAX);
            end else if (e > 0) begin
                r.sign = (sum < 0);
                r.exp  = `FP_EXP_W'(e);
                r.frac = `FP_FRAC_W'((mag - (1 << p)) << (`FP_FRAC_W - p));   // drop hidden one
            end
        end
        return r;
    endfunction

    function automatic bfp_block_t random_block(input int exp_min, input int exp_max);
        bfp_block_t b;
        b.exp = `BFP_EXP_W'($urandom_range(exp_max, exp_min));
        for (int i = 0; i < `BFP_GRP_SIZE; i++) begin
            b.elem[i] = 4'($urandom);
        end
        return b;
    endfunction

    task automatic check_result(input fp32_t actual, input fp32_t expected);
        if (actual !== expected) begin
            $display("ERROR: o_result = %h, expected %h", actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_valid(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR: o_valid = %h, expected %h", actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "strobe timing mismatch");
        end
    endtask

    task automatic send_block(input bfp_block_t act, input bfp_block_t wgt);
        @(negedge clk);
        in_valid  = 1'b1;
        in_act    = act;
        in_weight = wgt;
        exp_q.push_back(expected_result(act, wgt));
    endtask

    // drop the strobe, then wait for every pending result
    task automatic finish_burst();
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic test_zero_cancel();
        bfp_block_t a;
        bfp_block_t w;
        a = random_block(100, 140);
        w = random_block(100, 140);
        for (int i = 0; i < `BFP_GRP_SIZE; i++) begin
            a.elem[i].frac = '0;
        end
        send_block(a, w);
        a = random_block(100, 140);
        w = random_block(100, 140);
        for (int i = 0; i < HALF; i++) begin
            a.elem[i+HALF]      = a.elem[i];
            w.elem[i+HALF]      = w.elem[i];
            a.elem[i+HALF].sign = ~a.elem[i].sign;   // mirror term cancels
        end
        send_block(a, w);
        finish_burst();
    endtask

    task automatic test_single_product();
        bfp_block_t a;
        bfp_block_t w;
        a     = '0;
        w     = '0;
        a.exp = 8'd100;
        w.exp = 8'd27;
        a.elem[5] = {1'b0, 3'd5};
        w.elem[5] = {1'b1, 3'd3};   // -15/64 at exponent 124
        send_block(a, w);
        finish_burst();
    endtask

    task automatic test_mixed_signs();
        repeat (20) begin
            send_block(random_block(20, 120), random_block(20, 120));
            finish_burst();
        end
    endtask

    task automatic test_overflow();
        bfp_block_t a;
        bfp_block_t w;
        a     = '0;
        w     = '0;
        a.exp = 8'd200;
        w.exp = 8'd200;
        for (int i = 0; i < `BFP_GRP_SIZE; i++) begin
            a.elem[i].frac = 3'($urandom_range(7, 1));
            w.elem[i].frac = 3'($urandom_range(7, 1));
        end
        send_block(a, w);
        for (int i = 0; i < `BFP_GRP_SIZE; i++) begin
            a.elem[i].sign = 1'b1;
        end
        send_block(a, w);
        finish_burst();
    endtask

    task automatic test_flush();
        bfp_block_t a;
        bfp_block_t w;
        a = '0;
        w = '0;
        a.elem[0] = {1'b0, 3'd1};
        w.elem[0] = {1'b1, 3'd1};
        send_block(a, w);
        a.elem[0] = {1'b0, 3'd7};
        w.elem[0] = {1'b0, 3'd7};
        send_block(a, w);
        finish_burst();
    endtask

    task automatic test_streaming();
        repeat (100) begin
            send_block(random_block(0, 255), random_block(0, 255));
        end
        finish_burst();
    endtask

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vld_hist <= '0;
        end else begin
            vld_hist <= {vld_hist[1:0], in_valid};
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        check_valid(out_valid, vld_hist[2]);
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                $display("o_valid went high with no result pending");
                $display("ERRORS FOUND");
                $fatal(1, "unexpected output strobe");
            end else begin
                check_result(out_result, exp_q.pop_front());
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $fatal(1, "timeout");
    end

    initial begin
        in_valid  = 1'b0;
        in_act    = '0;
        in_weight = '0;
        reset_n   = 1'b0;
        void'($urandom(32'h8d6e2dfb));
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        repeat (3) @(negedge clk);   // o_valid must stay low while idle

        test_zero_cancel();
        test_single_product();
        test_mixed_signs();
        test_overflow();
        test_flush();
        test_streaming();

        repeat (4) @(negedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/bfp_pkg.sv
hdl/bfp_product_array.sv
hdl/bfp_adder_tree.sv
hdl/fp_normalize.sv
hdl/bfp_dot_product.sv
tb/tb_clock_gen.sv
tb/tb_bfp_dot_product.sv

//--- Makefile
TOP = tb_bfp_dot_product

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f tb.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; rc=$$?; cat sim.log; \
	if [ $$rc -ne 0 ] || grep -q "ERRORS FOUND" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
